// File: hw/uart_tx_pkg.sv
`default_nettype none

package uart_tx_pkg;

    // word and character geometry
    parameter int WORD_W         = 32;
    parameter int BYTE_W         = 8;
    parameter int BYTES_PER_WORD = WORD_W / BYTE_W;

    // 50 MHz at 115200 baud
    parameter int DEFAULT_CLKS_PER_BIT = 434;

    // what the line carries during the current bit time
    typedef enum logic [2:0] {
        PH_IDLE,  // line high, waiting for valid edge
        PH_START, // start bit, line low
        PH_DATA,  // one of eight data bits
        PH_STOP,  // stop bit
        PH_GAP    // one idle bit between characters
    } line_phase_t;

endpackage : uart_tx_pkg

`default_nettype wire

// File: hw/baud_timer.sv
`default_nettype none

module baud_timer #(
    parameter int CLKS_PER_BIT = uart_tx_pkg::DEFAULT_CLKS_PER_BIT
) (
    input  wire  CLK_I,
    input  wire  RSTL_I,
    input  wire  timer_clear,
    output logic bit_tick
);
    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            cnt <= '0;
        end else if (timer_clear) begin
            cnt <= '0; // realign to the start bit
        end else if (cnt == LAST_CNT) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // last clock of each bit period
    assign bit_tick = (cnt == LAST_CNT);

endmodule : baud_timer

`default_nettype wire

// File: hw/word_serializer.sv
`default_nettype none

module word_serializer (
    input  wire                            CLK_I,
    input  wire                            RSTL_I,
    input  wire                            load,
    input  wire                            shift,
    input  wire [uart_tx_pkg::WORD_W-1:0] tx_data,
    input  wire uart_tx_pkg::line_phase_t  phase,
    output logic                           tx_line
);
    import uart_tx_pkg::*;

    logic [WORD_W-1:0] shreg;

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            shreg <= '0;
        end else if (load) begin
            shreg <= tx_data;
        end else if (shift) begin
            shreg <= {1'b0, shreg[WORD_W-1:1]}; // LSB first, byte 0 first
        end
    end

    always_comb begin
        case (phase)
            PH_START: tx_line = 1'b0;
            PH_DATA:  tx_line = shreg[0];
            default:  tx_line = 1'b1; // idle, stop and gap
        endcase
    end

endmodule : word_serializer

`default_nettype wire

// File: hw/uart_word_ctrl.sv
`default_nettype none

module uart_word_ctrl (
    input  wire                      CLK_I,
    input  wire                      RSTL_I,
    input  wire                      tx_valid,
    input  wire                      bit_tick,
    output logic                     tx_ready,
    output logic                     load,
    output logic                     shift,
    output logic                     timer_clear,
    output uart_tx_pkg::line_phase_t phase
);
    import uart_tx_pkg::*;

    localparam int BIT_CNT_W  = $clog2(BYTE_W);
    localparam int BYTE_CNT_W = $clog2(BYTES_PER_WORD);

    localparam logic [BIT_CNT_W-1:0]  LAST_BIT  = BIT_CNT_W'(BYTE_W - 1);
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(BYTES_PER_WORD - 1);

    logic                  valid_prev;
    logic                  start_word;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [BYTE_CNT_W-1:0] byte_cnt;

    // rising edge of valid, honoured only when nothing is in flight
    assign start_word = tx_valid && !valid_prev && (phase == PH_IDLE);

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            valid_prev  <= 1'b0; // a valid already high at reset end counts
            load        <= 1'b0;
            timer_clear <= 1'b0;
        end else begin
            valid_prev  <= tx_valid;
            load        <= start_word;  // word copied on the next edge
            timer_clear <= start_word;  // bit timer aligned to start bit
        end
    end

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            phase    <= PH_IDLE;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (timer_clear) begin // start pending from last cycle
                        phase    <= PH_START;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                    end
                end
                PH_START: begin
                    if (bit_tick) begin
                        phase   <= PH_DATA;
                        bit_cnt <= '0;
                    end
                end
                PH_DATA: begin
                    if (bit_tick) begin
                        if (bit_cnt == LAST_BIT) begin
                            phase <= PH_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                PH_STOP: begin
                    if (bit_tick) begin
                        if (byte_cnt == LAST_BYTE) begin
                            phase <= PH_IDLE; // word done
                        end else begin
                            phase    <= PH_GAP;
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                PH_GAP: begin
                    if (bit_tick) begin
                        phase <= PH_START;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // serializer moves on at the same edge the next data bit begins
    assign shift = bit_tick && (phase == PH_DATA);

    assign tx_ready = (phase == PH_IDLE);

endmodule : uart_word_ctrl

`default_nettype wire

// File: hw/word_uart_tx.sv
`default_nettype none

module word_uart_tx #(
    parameter int CLKS_PER_BIT = uart_tx_pkg::DEFAULT_CLKS_PER_BIT
) (
    input  wire                            CLK_I,
    input  wire                            RSTL_I,
    input  wire                            tx_valid,
    input  wire [uart_tx_pkg::WORD_W-1:0] tx_data,
    output logic                           tx_line,
    output logic                           tx_ready
);
    import uart_tx_pkg::*;

    line_phase_t phase;
    logic        bit_tick;
    logic        timer_clear;
    logic        load;
    logic        shift;

    // frame sequencing
    uart_word_ctrl u_ctrl (
        .CLK_I       (CLK_I),
        .RSTL_I      (RSTL_I),
        .tx_valid    (tx_valid),
        .bit_tick    (bit_tick),
        .tx_ready    (tx_ready),
        .load        (load),
        .shift       (shift),
        .timer_clear (timer_clear),
        .phase       (phase)
    );

    baud_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_timer (
        .CLK_I       (CLK_I),
        .RSTL_I      (RSTL_I),
        .timer_clear (timer_clear),
        .bit_tick    (bit_tick)
    );

    // word storage and line level
    word_serializer u_ser (
        .CLK_I   (CLK_I),
        .RSTL_I  (RSTL_I),
        .load    (load),
        .shift   (shift),
        .tx_data (tx_data),
        .phase   (phase),
        .tx_line (tx_line)
    );

endmodule : word_uart_tx

`default_nettype wire

// File: sim/tb_word_uart_tx.sv
`default_nettype none

module tb_word_uart_tx;
    import uart_tx_pkg::*;

    localparam int CLKS_PER_BIT  = 8;
    localparam int NUM_FIXED     = 5;
    localparam int NUM_RANDOM    = 3;
    localparam int NUM_TESTS     = NUM_FIXED + NUM_RANDOM;
    localparam int CHAR_BITS     = BYTE_W + 2;  // start, data, stop
    localparam int FRAME_BITS    = BYTES_PER_WORD * CHAR_BITS + (BYTES_PER_WORD - 1);
    localparam int FRAME_CLKS    = FRAME_BITS * CLKS_PER_BIT;
    localparam int START_LATENCY = 2;  // edge seen at k, line low after k+1
    localparam int IDLE_AFTER    = 20 * CLKS_PER_BIT;
    localparam int EXTRA_AT      = 20 * CLKS_PER_BIT;  // mid-frame extra pulse
    localparam int HOLD_CYCLES   = FRAME_CLKS + 5 * CLKS_PER_BIT;
    localparam int WATCHDOG_CLKS = (NUM_TESTS + 2) * FRAME_BITS * CLKS_PER_BIT * 2;

    logic              CLK_I;
    logic              RSTL_I;
    logic              tx_valid;
    logic [WORD_W-1:0] tx_data;
    logic              tx_line;
    logic              tx_ready;

    // stimulus table
    string             test_name  [NUM_TESTS];
    logic [WORD_W-1:0] test_word  [NUM_TESTS];
    int                test_width [NUM_TESTS];
    bit                test_extra [NUM_TESTS];

    logic [WORD_W-1:0] rx_word;  // rebuilt by the receiver model
    int                test_errors;
    int                total_errors;
    int                tests_run;
    int                tests_failed;

    word_uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut (
        .CLK_I    (CLK_I),
        .RSTL_I   (RSTL_I),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_line  (tx_line),
        .tx_ready (tx_ready)
    );

    initial begin
        CLK_I = 1'b0;
        forever #20 CLK_I = ~CLK_I;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge CLK_I);
        $display("timeout: run did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic report_mismatch(input string name, input string what,
                                   input logic [WORD_W-1:0] expected,
                                   input logic [WORD_W-1:0] actual);
        $display("[FAIL] %s: %s expected %0h, got %0h", name, what, expected, actual);
        test_errors++;
    endtask

    task automatic report_problem(input string name, input string what);
        $display("ERROR %s: %s", name, what);
        test_errors++;
    endtask

    task automatic set_entry(input int idx, input string name, input logic [WORD_W-1:0] word,
                             input int width, input bit extra);
        test_name[idx]  = name;
        test_word[idx]  = word;
        test_width[idx] = width;
        test_extra[idx] = extra;
    endtask

    task automatic fill_table();
        int i;

        set_entry(0, "ascii_abcd", 32'h44434241, 1, 1'b0);
        set_entry(1, "all_zero", 32'h00000000, 3, 1'b0);
        set_entry(2, "all_ones", 32'hFFFFFFFF, 1, 1'b1);
        set_entry(3, "mixed_bits", 32'hA5C30F96, 2, 1'b1);
        set_entry(4, "valid_held", 32'h80017FFE, HOLD_CYCLES, 1'b0);
        for (i = 0; i < NUM_RANDOM; i++) begin
            set_entry(NUM_FIXED + i, $sformatf("random_%0d", i), $urandom(),
                      1 + int'($urandom % 4), bit'($urandom % 2));
        end
    endtask

    // valid pulse, plus a second one with other data while the frame runs
    task automatic drive_valid(input logic [WORD_W-1:0] word, input int width,
                               input bit extra);
        tx_data  = word;
        tx_valid = 1'b1;
        repeat (width) @(negedge CLK_I);
        tx_valid = 1'b0;
        if (extra) begin
            repeat (EXTRA_AT - width) @(negedge CLK_I);
            tx_data  = ~word;
            tx_valid = 1'b1;
            repeat (2) @(negedge CLK_I);
            tx_valid = 1'b0;
        end
    endtask

    // receiver model, samples the line mid-cycle on falling clock edges
    task automatic check_frame(input string name);
        int                    wait_cnt;
        int                    b;
        int                    k;
        int                    chr;
        int                    pos;
        logic                  mid;
        logic [FRAME_CLKS-1:0] samples;
        bit                    ready_ok;
        bit                    idle_ok;

        rx_word  = '0;
        wait_cnt = 0;
        ready_ok = 1'b1;
        idle_ok  = 1'b1;
        do begin
            @(negedge CLK_I);
            wait_cnt++;
            if (tx_line === 1'b1 && tx_ready !== 1'b1) begin
                report_problem(name, "ready low while the line is still idle");
            end
        end while (tx_line === 1'b1 && wait_cnt < 4 * CLKS_PER_BIT);

        if (tx_line !== 1'b0) begin
            report_problem(name, "no start bit seen on the line");
            return;
        end
        if (wait_cnt != START_LATENCY) begin
            report_mismatch(name, "clocks from valid to start bit", START_LATENCY, wait_cnt);
        end

        for (k = 0; k < FRAME_CLKS; k++) begin
            if (k > 0) begin
                @(negedge CLK_I);
            end
            samples[k] = tx_line;
            if (tx_ready !== 1'b0) begin
                ready_ok = 1'b0;
            end
        end
        if (!ready_ok) begin
            report_problem(name, "ready went high before the frame ended");
        end

        for (b = 0; b < FRAME_BITS; b++) begin
            mid = samples[b * CLKS_PER_BIT + CLKS_PER_BIT / 2];
            for (k = 0; k < CLKS_PER_BIT; k++) begin
                if (samples[b * CLKS_PER_BIT + k] !== mid) begin
                    report_problem(name, $sformatf("line changed inside bit time %0d", b));
                    break;
                end
            end
            chr = b / (CHAR_BITS + 1);  // character plus its gap
            pos = b % (CHAR_BITS + 1);
            case (pos)
                0: begin
                    if (mid !== 1'b0) begin
                        report_mismatch(name, $sformatf("start bit %0d", chr), 0,
                                        WORD_W'(mid));
                    end
                end
                CHAR_BITS - 1: begin
                    if (mid !== 1'b1) begin
                        report_mismatch(name, $sformatf("stop bit %0d", chr), 1,
                                        WORD_W'(mid));
                    end
                end
                CHAR_BITS: begin
                    if (mid !== 1'b1) begin
                        report_mismatch(name, $sformatf("gap after byte %0d", chr), 1,
                                        WORD_W'(mid));
                    end
                end
                default: begin
                    rx_word = {mid, rx_word[WORD_W-1:1]};  // LSB arrives first
                end
            endcase
        end

        for (k = 0; k < IDLE_AFTER; k++) begin
            @(negedge CLK_I);
            if (k == 0 && tx_ready !== 1'b1) begin
                report_mismatch(name, "ready at frame end", 1, WORD_W'(tx_ready));
            end
            if (tx_line !== 1'b1 || tx_ready !== 1'b1) begin
                idle_ok = 1'b0;
            end
        end
        if (!idle_ok) begin
            report_problem(name, "line or ready left idle after the frame");
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, test_errors);
        end
    endtask

    task automatic check_reset_state();
        test_errors = 0;
        @(negedge CLK_I);
        if (tx_line !== 1'b1) begin
            report_mismatch("reset_idle", "tx_line", 1, WORD_W'(tx_line));
        end
        if (tx_ready !== 1'b1) begin
            report_mismatch("reset_idle", "tx_ready", 1, WORD_W'(tx_ready));
        end
        finish_test("reset_idle");
    endtask

    task automatic run_test(input int idx);
        test_errors = 0;
        fork
            drive_valid(test_word[idx], test_width[idx], test_extra[idx]);
            check_frame(test_name[idx]);
        join
        if (rx_word !== test_word[idx]) begin
            report_mismatch(test_name[idx], "word", test_word[idx], rx_word);
        end
        finish_test(test_name[idx]);
    endtask

    initial begin
        int i;

        RSTL_I       = 1'b0;
        tx_valid     = 1'b0;
        tx_data      = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(76737));
        fill_table();

        repeat (4) @(negedge CLK_I);
        RSTL_I = 1'b1;
        check_reset_state();

        for (i = 0; i < NUM_TESTS; i++) begin
            repeat (2) @(negedge CLK_I);  // valid low before the next edge
            run_test(i);
        end

        $display("tests: %0d run, %0d passed, %0d failed, %0d failed checks",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_word_uart_tx

`default_nettype wire

// File: src.f
hw/uart_tx_pkg.sv
hw/baud_timer.sv
hw/word_serializer.sv
hw/uart_word_ctrl.sv
hw/word_uart_tx.sv
sim/tb_word_uart_tx.sv

// File: Makefile
# Verilator build and run for the word UART transmitter
#
#   make compile   build the simulation binary
#   make run       run it and check the log for the pass message
#   make clean     remove build output and log

VERILATOR ?= verilator
TOP       ?= tb_word_uart_tx
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?=

PASS_TEXT := *** TEST PASSED ***

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing -j $(JOBS) \
		--top-module $(TOP) \
		-Mdir $(BUILD_DIR) \
		-f $(FILELIST) \
		$(VFLAGS)

# the log decides, so a crash or timeout also fails
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
